/* tb.f */
+incdir+logic
logic/cu_pkg.sv
logic/decode_if.sv
logic/instr_decoder.sv
logic/ctrl_sequencer.sv
logic/control_unit.sv
verification/tb_control_unit.sv

/* Bender.yml */
package:
  name: control_unit

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/cu_pkg.sv
      - logic/decode_if.sv
      - logic/instr_decoder.sv
      - logic/ctrl_sequencer.sv
      - logic/control_unit.sv

  - target: simulation
    include_dirs:
      - logic
    files:
      - verification/tb_control_unit.sv

/* verification/tb_control_unit.sv */
// Control unit testbench
// Directed and random instruction stream checked against a reference decode table
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

module tb_control_unit;

    localparam int N_RAND    = 3;   // Random words per opcode in the ALU group
    localparam int HALT_IDLE = 10;  // Cycles watched after HALT
    // Reset, ALU group, LOAD/STORE, JUMP, JZ/JNZ, NOT words, HALT, idle, closing
    localparam int RUN_CYCLES  = 8 + 2 * 11 * N_RAND + 2 * 4 + 2 * 2 + 3 * 4 + 2 * 3 + 2
                                 + HALT_IDLE + 2;
    localparam int CYCLE_LIMIT = 4 * RUN_CYCLES + 50;
    localparam logic [3:0] ALU_GROUP [0:10] = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5,
                                                4'd8, 4'd9, 4'd10, 4'd11, 4'd15};

    logic                      clk = 1'b0;   // Low from the start, first edge rises
    logic                      rst;
    logic [`CU_INSTR_W-1:0]    instruction;
    logic                      zero_flag;
    logic                      pc_enable, pc_load, reg_write_enable, mem_write_enable;
    logic [`CU_ALU_OP_W-1:0]   alu_op;
    logic [`CU_REG_ADDR_W-1:0] reg1_addr, reg2_addr, reg_dest_addr;
    logic [`CU_DATA_W-1:0]     immediate;
    logic                      use_immediate, mem_addr_sel, load_from_mem, halt;

    // Expected outputs for the coming cycle
    logic [5:0]                exp_strobes;  // pc_en, pc_load, reg_we, mem_we, addr_sel, load
    logic [`CU_ALU_OP_W-1:0]   exp_alu_op;
    logic [`CU_REG_ADDR_W-1:0] exp_reg1, exp_reg2, exp_dest;
    logic [`CU_DATA_W-1:0]     exp_imm;
    logic                      exp_use_imm, exp_halt;
    // Reference decode of the current word
    logic                      d_wr, d_mw, d_ms, d_ld, d_halt;
    logic [1:0]                d_kind;       // 0 none, 1 jump, 2 jz, 3 jnz

    integer seed;
    integer rnd;
    integer err_count, test_mark, tests_passed, tests_failed, cycle_count;
    string  pending_name;
    logic   report_due;

    control_unit uut (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    // Decode table taken from the instruction set, word layout op|r1|r2|imm6
    task automatic ref_decode(input logic [15:0] w);
        {d_wr, d_mw, d_ms, d_ld, d_halt, d_kind} = '0;
        exp_alu_op  = 4'd0;
        exp_reg1    = w[11:9];
        exp_reg2    = w[8:6];
        exp_dest    = 3'd0;
        exp_imm     = {2'b00, w[5:0]};
        exp_use_imm = 1'b0;
        case (w[15:12])
            4'd0:  {exp_dest, exp_reg1, exp_alu_op, exp_use_imm, d_wr} = {w[11:9], 3'd0, 4'd13, 2'b11};
            4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
                exp_dest   = w[8:6];
                exp_alu_op = w[15:12] - 4'd1;    // ADD..XOR map to 0..4
                d_wr       = 1'b1;
            end
            4'd6:  {d_mw, d_ms} = 2'b11;         // STORE
            4'd7:  {exp_dest, exp_reg1, exp_alu_op, d_ms, d_ld, d_wr} = {w[11:9], 3'd0, 4'd12, 3'b111};
            4'd8:  {exp_dest, exp_alu_op, d_wr} = {w[8:6], 4'd6, 1'b1};
            4'd9:  {exp_dest, exp_alu_op, d_wr} = {w[8:6], 4'd7, 1'b1};
            4'd10: {exp_dest, exp_alu_op, d_wr} = {w[8:6], 4'd12, 1'b1};
            4'd11: exp_alu_op = 4'd1;            // CMP, flags only
            4'd12: d_kind = 2'd1;
            4'd13, 4'd14: begin
                exp_alu_op  = 4'd1;
                exp_use_imm = 1'b1;
                exp_imm     = 8'd0;
                d_kind      = (w[15:12] == 4'd13) ? 2'd2 : 2'd3;
            end
            default: begin
                if (w[11:0] == 12'd0) d_halt = 1'b1;
                else {exp_dest, exp_alu_op, d_wr} = {w[8:6], 4'd5, 1'b1};
            end
        endcase
    endtask

    // One instruction from its FETCH edge to its last strobe cycle
    task automatic run_instr(input logic [15:0] word, input logic zf);
        logic   taken;
        integer pc_seen;
        pc_seen     = 0;
        instruction = word;
        zero_flag   = zf;
        exp_strobes = '0;                        // FETCH edge issues nothing
        @(negedge clk);
        pc_seen = pc_seen + pc_enable + pc_load;
        ref_decode(word);
        if (d_halt) begin
            exp_strobes = '0;
            exp_halt    = 1'b1;
        end else if (d_kind[1]) exp_strobes = '0;  // Conditional waits for EXECUTE
        else exp_strobes = {d_kind == 2'd0, d_kind == 2'd1, d_wr, d_mw, d_ms, d_ld};
        @(negedge clk);
        pc_seen = pc_seen + pc_enable + pc_load;
        if (d_kind[1]) begin
            taken       = (d_kind == 2'd2) ? zf : !zf;
            exp_strobes = {!taken, taken, 4'b0000};
            @(negedge clk);
            pc_seen = pc_seen + pc_enable + pc_load;
        end
        a_one_pc_strobe : assert (pc_seen == (d_halt ? 0 : 1))
            else begin
                err_count = err_count + 1;
                $display("[ERROR] %0t word %h gave %0d PC strobes", $time, word, pc_seen);
            end
    endtask

    task automatic close_test(input string name);
        pending_name = name;
        report_due   = 1'b1;
    endtask

    // Reported on the rising edge so the falling-edge checks have all landed
    always @(posedge clk) begin
        if (report_due) begin
            report_due = 1'b0;
            if (err_count == test_mark) tests_passed = tests_passed + 1;
            else tests_failed = tests_failed + 1;
            $display("[%0t] %-10s %s (%0d errors)", $time, pending_name,
                     (err_count == test_mark) ? "ok" : "failed", err_count - test_mark);
            test_mark = err_count;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    a_strobes : assert property (@(negedge clk)
        {pc_enable, pc_load, reg_write_enable, mem_write_enable, mem_addr_sel, load_from_mem}
            == exp_strobes)
        else begin
            err_count = err_count + 1;
            $display("[ERROR] %0t strobes %b, expected %b", $time,
                     $sampled({pc_enable, pc_load, reg_write_enable, mem_write_enable,
                               mem_addr_sel, load_from_mem}), $sampled(exp_strobes));
        end

    a_fields : assert property (@(negedge clk)
        {alu_op, reg1_addr, reg2_addr, reg_dest_addr, immediate, use_immediate}
            == {exp_alu_op, exp_reg1, exp_reg2, exp_dest, exp_imm, exp_use_imm})
        else begin
            err_count = err_count + 1;
            $display("[ERROR] %0t fields alu %h r1 %0d r2 %0d rd %0d imm %h ui %b, expected %h",
                     $time, $sampled(alu_op), $sampled(reg1_addr), $sampled(reg2_addr),
                     $sampled(reg_dest_addr), $sampled(immediate), $sampled(use_immediate),
                     $sampled({exp_alu_op, exp_reg1, exp_reg2, exp_dest, exp_imm, exp_use_imm}));
        end

    a_halt : assert property (@(negedge clk) halt == exp_halt)
        else begin
            err_count = err_count + 1;
            $display("[ERROR] %0t halt %b, expected %b", $time, $sampled(halt), $sampled(exp_halt));
        end

    a_pc_exclusive : assert property (@(negedge clk) !(pc_enable && pc_load))
        else begin
            err_count = err_count + 1;
            $display("[ERROR] %0t pc_enable and pc_load high together", $time);
        end

    initial begin
        seed = 56;
        {err_count, test_mark, tests_passed, tests_failed, cycle_count} = '0;
        report_due  = 1'b0;
        rst         = 1'b1;
        instruction = '0;
        zero_flag   = 1'b0;
        {exp_strobes, exp_alu_op, exp_reg1, exp_reg2, exp_dest} = '0;
        {exp_imm, exp_use_imm, exp_halt} = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;                              // Next rising edge is the first FETCH
        close_test("reset");

        foreach (ALU_GROUP[i]) begin
            repeat (N_RAND) begin
                rnd = $random(seed);
                if (ALU_GROUP[i] == 4'd15 && rnd[11:0] == 12'd0) rnd[0] = 1'b1;  // Keep NOT
                run_instr({ALU_GROUP[i], rnd[11:0]}, rnd[12]);
            end
        end
        close_test("alu_ops");

        repeat (2) begin
            rnd = $random(seed);
            run_instr({4'd7, rnd[11:0]}, 1'b0);  // LOAD
            run_instr({4'd6, rnd[23:12]}, 1'b0); // STORE
        end
        close_test("memory");

        rnd = $random(seed);
        run_instr({4'd12, rnd[11:0]}, 1'b0);
        run_instr({4'd12, rnd[23:12]}, 1'b1);
        run_instr(16'hD2C5, 1'b1);               // JZ taken
        run_instr(16'hD2C5, 1'b0);
        run_instr(16'hE13F, 1'b1);
        run_instr(16'hE13F, 1'b0);               // JNZ taken
        close_test("branches");

        run_instr(16'hF001, 1'b0);               // Opcode 15, nonzero operand is NOT
        run_instr(16'hF800, 1'b0);
        run_instr(16'hFFFF, 1'b1);
        run_instr(16'hF000, 1'b0);               // HALT
        repeat (HALT_IDLE) begin
            rnd         = $random(seed);
            instruction = rnd[15:0];             // Ignored while halted
            zero_flag   = rnd[16];
            @(negedge clk);
        end
        close_test("not_halt");

        @(posedge clk);
        @(negedge clk);
        $display("Tests: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/control_unit.sv */
// CPU control unit top
// Decoder and sequencer joined through the decode bundle, plain ports outside
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

module control_unit (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic [`CU_INSTR_W-1:0]    instruction,      // From instruction memory
    input  wire logic                      zero_flag,        // From ALU
    output logic                           pc_enable,        // PC + 1
    output logic                           pc_load,          // PC = target
    output logic                           reg_write_enable,
    output logic                           mem_write_enable,
    output logic [`CU_ALU_OP_W-1:0]        alu_op,
    output logic [`CU_REG_ADDR_W-1:0]      reg1_addr,        // Source A
    output logic [`CU_REG_ADDR_W-1:0]      reg2_addr,        // Source B
    output logic [`CU_REG_ADDR_W-1:0]      reg_dest_addr,
    output logic [`CU_DATA_W-1:0]          immediate,
    output logic                           use_immediate,    // ALU B mux
    output logic                           mem_addr_sel,     // Data address from immediate
    output logic                           load_from_mem,    // Writeback mux
    output logic                           halt
);

    // Decoded control for the current word
    decode_if dec_bus ();

    instr_decoder u_decoder (
        .instruction (instruction),
        .dec         (dec_bus)
    );

    ctrl_sequencer u_sequencer (
        .clk              (clk),
        .rst              (rst),
        .dec              (dec_bus),
        .zero_flag        (zero_flag),
        .pc_enable        (pc_enable),
        .pc_load          (pc_load),
        .reg_write_enable (reg_write_enable),
        .mem_write_enable (mem_write_enable),
        .alu_op           (alu_op),
        .reg1_addr        (reg1_addr),
        .reg2_addr        (reg2_addr),
        .reg_dest_addr    (reg_dest_addr),
        .immediate        (immediate),
        .use_immediate    (use_immediate),
        .mem_addr_sel     (mem_addr_sel),
        .load_from_mem    (load_from_mem),
        .halt             (halt)
    );

endmodule

`default_nettype wire

/* logic/ctrl_sequencer.sv */
// Control sequencer
// FETCH/DECODE/EXECUTE/HALT FSM, registers the control outputs and resolves branches
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

module ctrl_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    decode_if.sink                    dec,
    input  logic                      zero_flag,        // From ALU, valid in EXECUTE
    output logic                      pc_enable,
    output logic                      pc_load,
    output logic                      reg_write_enable,
    output logic                      mem_write_enable,
    output logic [`CU_ALU_OP_W-1:0]   alu_op,
    output logic [`CU_REG_ADDR_W-1:0] reg1_addr,
    output logic [`CU_REG_ADDR_W-1:0] reg2_addr,
    output logic [`CU_REG_ADDR_W-1:0] reg_dest_addr,
    output logic [`CU_DATA_W-1:0]     immediate,
    output logic                      use_immediate,
    output logic                      mem_addr_sel,
    output logic                      load_from_mem,
    output logic                      halt
);

    cu_pkg::state_e  state;
    cu_pkg::branch_e branch_q;      // Branch kind kept from DECODE
    logic            branch_taken;

    // JZ jumps on zero, JNZ on nonzero
    assign branch_taken = (branch_q == cu_pkg::BR_IF_ZERO) ? zero_flag : ~zero_flag;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state            <= cu_pkg::ST_FETCH;
            branch_q         <= cu_pkg::BR_NONE;
            pc_enable        <= 1'b0;
            pc_load          <= 1'b0;
            reg_write_enable <= 1'b0;
            mem_write_enable <= 1'b0;
            mem_addr_sel     <= 1'b0;
            load_from_mem    <= 1'b0;
            alu_op           <= '0;
            reg1_addr        <= '0;
            reg2_addr        <= '0;
            reg_dest_addr    <= '0;
            immediate        <= '0;
            use_immediate    <= 1'b0;
            halt             <= 1'b0;
        end else begin
            // Strobes last one cycle
            pc_enable        <= 1'b0;
            pc_load          <= 1'b0;
            reg_write_enable <= 1'b0;
            mem_write_enable <= 1'b0;
            mem_addr_sel     <= 1'b0;
            load_from_mem    <= 1'b0;

            case (state)
                cu_pkg::ST_FETCH: begin
                    state <= cu_pkg::ST_DECODE;  // Word already on the bus
                end

                cu_pkg::ST_DECODE: begin
                    // Operand fields move only here
                    alu_op        <= dec.alu_op;
                    reg1_addr     <= dec.reg1_addr;
                    reg2_addr     <= dec.reg2_addr;
                    reg_dest_addr <= dec.reg_dest_addr;
                    immediate     <= dec.immediate;
                    use_immediate <= dec.use_immediate;
                    branch_q      <= dec.branch;

                    if (dec.is_halt) begin
                        halt  <= 1'b1;
                        state <= cu_pkg::ST_HALT;
                    end else if (dec.branch == cu_pkg::BR_IF_ZERO ||
                                 dec.branch == cu_pkg::BR_IF_NONZERO) begin
                        state <= cu_pkg::ST_EXECUTE;  // Wait one cycle for the flag
                    end else begin
                        reg_write_enable <= dec.reg_write;
                        mem_write_enable <= dec.mem_write;
                        mem_addr_sel     <= dec.mem_addr_sel;
                        load_from_mem    <= dec.load_from_mem;
                        pc_load          <= (dec.branch == cu_pkg::BR_ALWAYS);
                        pc_enable        <= (dec.branch != cu_pkg::BR_ALWAYS);
                        state            <= cu_pkg::ST_FETCH;
                    end
                end

                cu_pkg::ST_EXECUTE: begin
                    pc_load   <= branch_taken;
                    pc_enable <= ~branch_taken;  // Fall through
                    state     <= cu_pkg::ST_FETCH;
                end

                cu_pkg::ST_HALT: begin
                    state <= cu_pkg::ST_HALT;  // Only reset leaves
                end
            endcase
        end
    end

    // PC is either stepped or loaded, never both
    a_pc_onehot : assert property (@(posedge clk) disable iff (rst)
        !(pc_enable && pc_load))
        else $error("pc_enable and pc_load high together");

    // Halt is sticky
    a_halt_sticky : assert property (@(posedge clk) disable iff (rst)
        halt |=> halt)
        else $error("halt dropped without reset");

    // A FETCH edge never issues work
    a_fetch_quiet : assert property (@(posedge clk) disable iff (rst)
        (state == cu_pkg::ST_FETCH) |=> !(pc_enable || pc_load || reg_write_enable ||
                                          mem_write_enable || mem_addr_sel || load_from_mem))
        else $error("strobe raised after a FETCH edge");

endmodule

`default_nettype wire

/* logic/instr_decoder.sv */
// Instruction decoder
// Combinational opcode table, 16-bit word to control bundle
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

module instr_decoder (
    input  cu_pkg::instr_u instruction,  // Held stable by the fetch stage
    decode_if.source       dec
);

    cu_pkg::instr_fields_t f;
    logic                  operand_zero;

    assign f            = instruction.fields;
    assign operand_zero = (instruction.split.operand == '0);  // HALT marker

    always_comb begin
        // Safe defaults, no writes, no branch
        dec.alu_op        = cu_pkg::ALU_ADD;
        dec.reg1_addr     = f.reg1;
        dec.reg2_addr     = f.reg2;
        dec.reg_dest_addr = '0;
        dec.immediate     = {{(`CU_DATA_W - `CU_IMM_W){1'b0}}, f.imm6};
        dec.use_immediate = 1'b0;
        dec.reg_write     = 1'b0;
        dec.mem_write     = 1'b0;
        dec.mem_addr_sel  = 1'b0;
        dec.load_from_mem = 1'b0;
        dec.branch        = cu_pkg::BR_NONE;
        dec.is_halt       = 1'b0;

        case (f.opcode)
            cu_pkg::OP_LOADI: begin
                dec.reg_dest_addr = f.reg1;          // reg1 is the target here
                dec.reg1_addr     = '0;              // R0 reads as zero
                dec.alu_op        = cu_pkg::ALU_PASS_B;
                dec.use_immediate = 1'b1;
                dec.reg_write     = 1'b1;
            end
            cu_pkg::OP_ADD: begin
                dec.reg_dest_addr = f.reg2;
                dec.alu_op        = cu_pkg::ALU_ADD;
                dec.reg_write     = 1'b1;
            end
            cu_pkg::OP_SUB: begin
                dec.reg_dest_addr = f.reg2;
                dec.alu_op        = cu_pkg::ALU_SUB;
                dec.reg_write     = 1'b1;
            end
            cu_pkg::OP_AND: begin
                dec.reg_dest_addr = f.reg2;
                dec.alu_op        = cu_pkg::ALU_AND;
                dec.reg_write     = 1'b1;
            end
            cu_pkg::OP_OR: begin
                dec.reg_dest_addr = f.reg2;
                dec.alu_op        = cu_pkg::ALU_OR;
                dec.reg_write     = 1'b1;
            end
            cu_pkg::OP_XOR: begin
                dec.reg_dest_addr = f.reg2;
                dec.alu_op        = cu_pkg::ALU_XOR;
                dec.reg_write     = 1'b1;
            end
            cu_pkg::OP_STORE: begin
                dec.mem_write    = 1'b1;   // reg1 data to Mem[imm]
                dec.mem_addr_sel = 1'b1;
            end
            cu_pkg::OP_LOAD: begin
                dec.reg_dest_addr = f.reg1;
                dec.reg1_addr     = '0;
                dec.alu_op        = cu_pkg::ALU_PASS_A;  // Result unused, data comes from memory
                dec.mem_addr_sel  = 1'b1;
                dec.load_from_mem = 1'b1;
                dec.reg_write     = 1'b1;
            end
            cu_pkg::OP_SHL: begin
                dec.reg_dest_addr = f.reg2;
                dec.alu_op        = cu_pkg::ALU_SHL;
                dec.reg_write     = 1'b1;
            end
            cu_pkg::OP_SHR: begin
                dec.reg_dest_addr = f.reg2;
                dec.alu_op        = cu_pkg::ALU_SHR;
                dec.reg_write     = 1'b1;
            end
            cu_pkg::OP_MOV: begin
                dec.reg_dest_addr = f.reg2;              // reg1 is the source
                dec.alu_op        = cu_pkg::ALU_PASS_A;
                dec.reg_write     = 1'b1;
            end
            cu_pkg::OP_CMP: begin
                dec.alu_op = cu_pkg::ALU_SUB;  // Flags only, result dropped
            end
            cu_pkg::OP_JUMP: begin
                dec.branch = cu_pkg::BR_ALWAYS;
            end
            cu_pkg::OP_JZ, cu_pkg::OP_JNZ: begin
                // reg1 - 0 drives the zero flag for the execute step
                dec.alu_op        = cu_pkg::ALU_SUB;
                dec.use_immediate = 1'b1;
                dec.immediate     = '0;
                dec.branch        = (f.opcode == cu_pkg::OP_JZ) ? cu_pkg::BR_IF_ZERO
                                                                : cu_pkg::BR_IF_NONZERO;
            end
            cu_pkg::OP_NOT_HALT: begin
                if (operand_zero) begin
                    dec.is_halt = 1'b1;
                end else begin
                    dec.reg_dest_addr = f.reg2;
                    dec.alu_op        = cu_pkg::ALU_NOT;
                    dec.reg_write     = 1'b1;
                end
            end
        endcase
    end

    // A halting word must never commit anything
    always_comb begin
        a_halt_no_write : assert final (!(dec.is_halt && (dec.reg_write || dec.mem_write)))
            else $error("HALT decoded with a write enable set");
    end

endmodule

`default_nettype wire

/* logic/decode_if.sv */
// Decoded control bundle
// Carries one instruction's control set from the decoder to the sequencer
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

interface decode_if;

    cu_pkg::alu_op_e           alu_op;
    logic [`CU_REG_ADDR_W-1:0] reg1_addr;
    logic [`CU_REG_ADDR_W-1:0] reg2_addr;
    logic [`CU_REG_ADDR_W-1:0] reg_dest_addr;
    logic [`CU_DATA_W-1:0]     immediate;      // Zero-extended imm6
    logic                      use_immediate;  // ALU B from immediate
    logic                      reg_write;
    logic                      mem_write;
    logic                      mem_addr_sel;   // Address from immediate
    logic                      load_from_mem;  // Writeback from memory
    cu_pkg::branch_e           branch;
    logic                      is_halt;

    // Decoder side
    modport source (
        output alu_op, reg1_addr, reg2_addr, reg_dest_addr, immediate, use_immediate,
        output reg_write, mem_write, mem_addr_sel, load_from_mem, branch, is_halt
    );

    // Sequencer side
    modport sink (
        input alu_op, reg1_addr, reg2_addr, reg_dest_addr, immediate, use_immediate,
        input reg_write, mem_write, mem_addr_sel, load_from_mem, branch, is_halt
    );

endinterface

`default_nettype wire

/* logic/cu_pkg.sv */
// Control unit types
// Opcodes, ALU functions, branch kinds, FSM states and instruction views
`default_nettype none

`include "cu_defs.svh"

package cu_pkg;

    // Instruction opcodes
    typedef enum logic [`CU_OPCODE_W-1:0] {
        OP_LOADI    = 4'd0,   // Rd(reg1) = imm
        OP_ADD      = 4'd1,
        OP_SUB      = 4'd2,
        OP_AND      = 4'd3,
        OP_OR       = 4'd4,
        OP_XOR      = 4'd5,
        OP_STORE    = 4'd6,   // Mem[imm] = reg1
        OP_LOAD     = 4'd7,   // Rd(reg1) = Mem[imm]
        OP_SHL      = 4'd8,
        OP_SHR      = 4'd9,
        OP_MOV      = 4'd10,  // Rd(reg2) = reg1
        OP_CMP      = 4'd11,  // Flags only
        OP_JUMP     = 4'd12,
        OP_JZ       = 4'd13,
        OP_JNZ      = 4'd14,
        OP_NOT_HALT = 4'd15   // Split by operand value
    } opcode_e;

    // ALU function codes, as the ALU expects them
    typedef enum logic [`CU_ALU_OP_W-1:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_NOT    = 4'd5,
        ALU_SHL    = 4'd6,
        ALU_SHR    = 4'd7,
        ALU_PASS_A = 4'd12,  // Operand A straight through
        ALU_PASS_B = 4'd13   // Operand B (reg2 or immediate)
    } alu_op_e;

    // How the PC moves after an instruction
    typedef enum logic [1:0] {
        BR_NONE,        // Sequential
        BR_ALWAYS,      // JUMP
        BR_IF_ZERO,     // JZ
        BR_IF_NONZERO   // JNZ
    } branch_e;

    // Sequencer states
    typedef enum logic [1:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,  // Conditional jumps only
        ST_HALT      // Sticky until reset
    } state_e;

    // Field view of the word
    typedef struct packed {
        opcode_e                    opcode;
        logic [`CU_REG_ADDR_W-1:0] reg1;
        logic [`CU_REG_ADDR_W-1:0] reg2;
        logic [`CU_IMM_W-1:0]      imm6;
    } instr_fields_t;

    // Opcode plus raw operand, used to tell HALT from NOT
    typedef struct packed {
        opcode_e                   opcode;
        logic [`CU_OPERAND_W-1:0] operand;
    } instr_split_t;

    typedef union packed {
        instr_fields_t fields;
        instr_split_t  split;
    } instr_u;

endpackage

`default_nettype wire

/* logic/cu_defs.svh */
// Control unit widths
// Instruction word layout, datapath and ALU select sizes
`ifndef CU_DEFS_SVH
`define CU_DEFS_SVH

// Instruction word
`define CU_INSTR_W     16   // Full instruction
`define CU_OPCODE_W    4    // Top nibble
`define CU_OPERAND_W   12   // Everything under the opcode

// Operand fields
`define CU_REG_ADDR_W  3    // Eight registers
`define CU_IMM_W       6    // Short immediate / address

// Datapath
`define CU_DATA_W      8    // Register and immediate width
`define CU_ALU_OP_W    4    // ALU function select

// Layout, MSB first
//   [15:12] opcode
//   [11:9]  reg1
//   [8:6]   reg2
//   [5:0]   imm6
// Opcode 1111 with all-zero operand is HALT, otherwise NOT

`endif
